// File: Makefile
# Verilator flow for the multiply/divide unit

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= muldiv_tb
RTL_TOP    ?= muldiv_unit
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert
PASS_MSG   ?= Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim: $(OBJ_DIR)/V$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+verification
logic/muldiv_pkg.sv
logic/wb_if.sv
logic/muldiv_issue.sv
logic/iter_divider.sv
logic/iter_multiplier.sv
logic/wb_arbiter.sv
logic/muldiv_unit.sv
verification/muldiv_tb.sv

// File: logic/iter_divider.sv
`timescale 1ns/1ps
`default_nettype none

module iter_divider (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  muldiv_pkg::div_cmd_t cmd,
    output logic                 idle,
    wb_if.requester              wb
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_req
    } state_e;

    state_e                         state;
    logic [$clog2(div_steps)-1:0]   step;

    logic [2*xlen-1:0] acc;         // remainder high, quotient low
    logic [xlen-1:0]   divisor;
    logic              neg_a;
    logic              neg_b;
    logic              is_rem;
    logic              is_word;
    logic [tag_w-1:0]  tag_q;

    logic              sgn_a;
    logic              sgn_b;
    logic [xlen:0]     diff;
    logic [xlen-1:0]   quo;
    logic [xlen-1:0]   rem;
    logic [xlen-1:0]   res;

    assign sgn_a = cmd.is_signed & cmd.dividend[xlen-1];
    assign sgn_b = cmd.is_signed & cmd.divisor[xlen-1];

    // trial subtract, top bit is the borrow
    assign diff = acc[2*xlen-1:xlen-1] - {1'b0, divisor};

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_busy;
                        step  <= '0;
                    end
                end
                st_busy: begin
                    step <= step + 1'b1;
                    if (step == $clog2(div_steps)'(div_steps - 1)) state <= st_req;
                end
                st_req: begin
                    if (wb.grant) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // datapath
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start && state == st_idle) begin
            acc     <= {{xlen{1'b0}}, sgn_a ? -cmd.dividend : cmd.dividend};
            divisor <= sgn_b ? -cmd.divisor : cmd.divisor;
            neg_a   <= sgn_a;
            neg_b   <= sgn_b;
            is_rem  <= cmd.is_rem;
            is_word <= cmd.is_word;
            tag_q   <= cmd.tag;
        end else if (state == st_busy) begin
            acc <= {diff[xlen] ? acc[2*xlen-2:xlen-1] : diff[xlen-1:0],
                    acc[xlen-2:0], ~diff[xlen]};
        end
    end

    // divide by zero forces all ones, remainder already equals the dividend
    // most negative / -1 needs no fix, magnitude 2^63 comes back unchanged
    assign quo = (divisor == '0) ? '1 :
                 (neg_a ^ neg_b) ? -acc[xlen-1:0] : acc[xlen-1:0];
    assign rem = neg_a ? -acc[2*xlen-1:xlen] : acc[2*xlen-1:xlen];
    assign res = is_rem ? rem : quo;

    assign idle       = (state == st_idle);
    assign wb.req     = (state == st_req);
    assign wb.payload = '{tag: tag_q,
                          data: is_word ? {{32{res[31]}}, res[31:0]} : res};

endmodule

`default_nettype wire

// File: logic/iter_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module iter_multiplier (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  muldiv_pkg::mul_cmd_t cmd,
    output logic                 idle,
    wb_if.requester              wb
);
    import muldiv_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_req
    } state_e;

    state_e                         state;
    logic [$clog2(mul_steps)-1:0]   step;

    logic [2*xlen-1:0] acc;         // product high, multiplier shifts out low
    logic [xlen-1:0]   mcand;
    logic              neg;
    logic              high;
    logic              is_word;
    logic [tag_w-1:0]  tag_q;

    logic              sgn_a;
    logic              sgn_b;
    logic [xlen+1:0]   pp;
    logic [xlen+1:0]   sum;
    logic [2*xlen-1:0] prod;
    logic [xlen-1:0]   res;

    assign sgn_a = cmd.a_signed & cmd.op_a[xlen-1];
    assign sgn_b = cmd.b_signed & cmd.op_b[xlen-1];

    // two multiplier bits per step, 0..3 times the multiplicand
    assign pp  = (acc[0] ? {2'b00, mcand} : '0) + (acc[1] ? {1'b0, mcand, 1'b0} : '0);
    assign sum = {2'b00, acc[2*xlen-1:xlen]} + pp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: if (start) begin
                    state <= st_busy;
                    step  <= '0;
                end
                st_busy: begin
                    step <= step + 1'b1;
                    if (step == $clog2(mul_steps)'(mul_steps - 1)) state <= st_req;
                end
                st_req: if (wb.grant) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == st_idle) begin
            acc     <= {{xlen{1'b0}}, sgn_b ? -cmd.op_b : cmd.op_b};
            mcand   <= sgn_a ? -cmd.op_a : cmd.op_a;
            neg     <= sgn_a ^ sgn_b;
            high    <= cmd.high;
            is_word <= cmd.is_word;
            tag_q   <= cmd.tag;
        end else if (state == st_busy) begin
            acc <= {sum, acc[xlen-1:2]};
        end
    end

    assign prod = neg ? -acc : acc;
    assign res  = high ? prod[2*xlen-1:xlen] : prod[xlen-1:0];

    assign idle       = (state == st_idle);
    assign wb.req     = (state == st_req);
    assign wb.payload = '{tag: tag_q,
                          data: is_word ? {{32{res[31]}}, res[31:0]} : res};

endmodule

`default_nettype wire

// File: logic/muldiv_issue.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_issue (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              in_valid,
    input  muldiv_pkg::muldiv_op_e            op,
    input  logic [muldiv_pkg::xlen-1:0]       src1,
    input  logic [muldiv_pkg::xlen-1:0]       src2,
    input  logic [muldiv_pkg::tag_w-1:0]      tag,
    output logic                              in_ready,
    input  logic                              div_idle,
    input  logic                              mul_idle,
    output logic                              div_start,
    output logic                              mul_start,
    output muldiv_pkg::div_cmd_t              div_cmd,
    output muldiv_pkg::mul_cmd_t              mul_cmd
);
    import muldiv_pkg::*;

    unit_sel_e       sel;
    logic            word;
    logic            ext_signed;
    logic [xlen-1:0] a_x;
    logic [xlen-1:0] b_x;

    assign sel  = op[2] ? unit_div : unit_mul;
    assign word = op[3];

    // only MULW exists as a word multiply, low half is sign agnostic
    assign ext_signed = (sel == unit_div) ? ~op[0] : 1'b1;
    assign a_x = word ? {{32{ext_signed & src1[31]}}, src1[31:0]} : src1;
    assign b_x = word ? {{32{ext_signed & src2[31]}}, src2[31:0]} : src2;

    assign in_ready  = (sel == unit_div) ? div_idle : mul_idle;
    assign div_start = in_valid & in_ready & (sel == unit_div);
    assign mul_start = in_valid & in_ready & (sel == unit_mul);

    assign div_cmd = '{dividend: a_x, divisor: b_x, is_signed: ~op[0],
                       is_rem: op[1], is_word: word, tag: tag};

    // MUL/MULW low half, MULH ss, MULHSU su, MULHU uu
    assign mul_cmd = '{op_a: a_x, op_b: b_x,
                       a_signed: (op[1:0] != 2'b11), b_signed: ~op[1],
                       high: (op[1:0] != 2'b00) & ~word, is_word: word, tag: tag};

endmodule

`default_nettype wire

// File: logic/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    localparam int xlen      = 64;
    localparam int tag_w     = 5;
    localparam int div_steps = 64;
    localparam int mul_steps = 32;

    // ----------------------------------------------------------------------
    // operation encoding
    // bit 3 word form, bit 2 divider, bits 1:0 follow funct3
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        op_mul    = 4'b0000,
        op_mulh   = 4'b0001,
        op_mulhsu = 4'b0010,
        op_mulhu  = 4'b0011,
        op_div    = 4'b0100,
        op_divu   = 4'b0101,
        op_rem    = 4'b0110,
        op_remu   = 4'b0111,
        op_mulw   = 4'b1000,
        op_divw   = 4'b1100,
        op_divuw  = 4'b1101,
        op_remw   = 4'b1110,
        op_remuw  = 4'b1111
    } muldiv_op_e;

    typedef enum logic {
        unit_mul = 1'b0,
        unit_div = 1'b1
    } unit_sel_e;

    typedef struct packed {
        logic [xlen-1:0]  dividend;
        logic [xlen-1:0]  divisor;
        logic             is_signed;
        logic             is_rem;
        logic             is_word;
        logic [tag_w-1:0] tag;
    } div_cmd_t;

    typedef struct packed {
        logic [xlen-1:0]  op_a;
        logic [xlen-1:0]  op_b;
        logic             a_signed;
        logic             b_signed;
        logic             high;
        logic             is_word;
        logic [tag_w-1:0] tag;
    } mul_cmd_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } wb_payload_t;

endpackage

`default_nettype wire

// File: logic/muldiv_unit.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  muldiv_pkg::muldiv_op_e       op,
    input  logic [muldiv_pkg::xlen-1:0]  src1,
    input  logic [muldiv_pkg::xlen-1:0]  src2,
    input  logic [muldiv_pkg::tag_w-1:0] tag,
    output logic                         in_ready,
    output logic                         result_valid,
    output logic [muldiv_pkg::tag_w-1:0] result_tag,
    output logic [muldiv_pkg::xlen-1:0]  result_data
);
    import muldiv_pkg::*;

    logic     div_idle;
    logic     mul_idle;
    logic     div_start;
    logic     mul_start;
    div_cmd_t div_cmd;
    mul_cmd_t mul_cmd;

    wb_if div_wb ();
    wb_if mul_wb ();

    muldiv_issue u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .src1      (src1),
        .src2      (src2),
        .tag       (tag),
        .in_ready  (in_ready),
        .div_idle  (div_idle),
        .mul_idle  (mul_idle),
        .div_start (div_start),
        .mul_start (mul_start),
        .div_cmd   (div_cmd),
        .mul_cmd   (mul_cmd)
    );

    iter_divider u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .start (div_start),
        .cmd   (div_cmd),
        .idle  (div_idle),
        .wb    (div_wb)
    );

    iter_multiplier u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .cmd   (mul_cmd),
        .idle  (mul_idle),
        .wb    (mul_wb)
    );

    wb_arbiter u_arb (
        .clk          (clk),
        .rst_n        (rst_n),
        .div_wb       (div_wb),
        .mul_wb       (mul_wb),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

// File: logic/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                         clk,
    input  logic                         rst_n,
    wb_if.arbiter                        div_wb,
    wb_if.arbiter                        mul_wb,
    output logic                         result_valid,
    output logic [muldiv_pkg::tag_w-1:0] result_tag,
    output logic [muldiv_pkg::xlen-1:0]  result_data
);
    import muldiv_pkg::*;

    logic        last_mul;      // multiplier was served last
    logic        div_gnt;
    logic        mul_gnt;
    wb_payload_t sel;

    // round robin only matters when both ask in the same cycle
    assign div_gnt = div_wb.req & (~mul_wb.req | last_mul);
    assign mul_gnt = mul_wb.req & (~div_wb.req | ~last_mul);

    assign div_wb.grant = div_gnt;
    assign mul_wb.grant = mul_gnt;

    assign sel = div_gnt ? div_wb.payload : mul_wb.payload;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            last_mul     <= 1'b0;
        end else begin
            result_valid <= div_gnt | mul_gnt;
            if (div_gnt | mul_gnt) last_mul <= mul_gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (div_gnt | mul_gnt) begin
            result_tag  <= sel.tag;
            result_data <= sel.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// one engine's request for the shared writeback bus
interface wb_if;
    import muldiv_pkg::*;

    logic        req;
    logic        grant;
    wb_payload_t payload;

    // req and payload held until grant
    modport requester (
        output req,
        output payload,
        input  grant
    );

    modport arbiter (
        input  req,
        input  payload,
        output grant
    );

endinterface

`default_nettype wire

// File: verification/muldiv_model.svh
`ifndef muldiv_model_svh
`define muldiv_model_svh

// expected results taken from the M-extension definitions

function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
endfunction

// full 128-bit product, each operand extended by its own signedness
function automatic logic [63:0] mul_ref(input logic [63:0] a, input logic [63:0] b,
                                        input logic sa, input logic sb, input logic hi);
    logic [127:0] xa;
    logic [127:0] xb;
    logic [127:0] p;
    xa = {{64{sa & a[63]}}, a};
    xb = {{64{sb & b[63]}}, b};
    p  = xa * xb;
    return hi ? p[127:64] : p[63:0];
endfunction

function automatic logic [63:0] div64_ref(input logic [63:0] a, input logic [63:0] b,
                                          input logic sgn, input logic rem);
    if (b == '0) return rem ? a : '1;
    if (sgn && a == 64'h8000_0000_0000_0000 && b == '1) return rem ? '0 : a;
    if (sgn) return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    return rem ? a % b : a / b;
endfunction

function automatic logic [31:0] div32_ref(input logic [31:0] a, input logic [31:0] b,
                                          input logic sgn, input logic rem);
    if (b == '0) return rem ? a : '1;
    if (sgn && a == 32'h8000_0000 && b == '1) return rem ? '0 : a;
    if (sgn) return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    return rem ? a % b : a / b;
endfunction

function automatic logic is_div_op(input muldiv_pkg::muldiv_op_e o);
    return o inside {muldiv_pkg::op_div, muldiv_pkg::op_divu, muldiv_pkg::op_rem,
                     muldiv_pkg::op_remu, muldiv_pkg::op_divw, muldiv_pkg::op_divuw,
                     muldiv_pkg::op_remw, muldiv_pkg::op_remuw};
endfunction

function automatic logic [63:0] ref_result(input muldiv_pkg::muldiv_op_e o,
                                           input logic [63:0] a, input logic [63:0] b);
    logic [63:0] lo;
    case (o)
        muldiv_pkg::op_mul:    return mul_ref(a, b, 1'b0, 1'b0, 1'b0);
        muldiv_pkg::op_mulh:   return mul_ref(a, b, 1'b1, 1'b1, 1'b1);
        muldiv_pkg::op_mulhsu: return mul_ref(a, b, 1'b1, 1'b0, 1'b1);
        muldiv_pkg::op_mulhu:  return mul_ref(a, b, 1'b0, 1'b0, 1'b1);
        muldiv_pkg::op_mulw: begin
            lo = a * b;
            return sext32(lo[31:0]);
        end
        muldiv_pkg::op_div:    return div64_ref(a, b, 1'b1, 1'b0);
        muldiv_pkg::op_divu:   return div64_ref(a, b, 1'b0, 1'b0);
        muldiv_pkg::op_rem:    return div64_ref(a, b, 1'b1, 1'b1);
        muldiv_pkg::op_remu:   return div64_ref(a, b, 1'b0, 1'b1);
        muldiv_pkg::op_divw:   return sext32(div32_ref(a[31:0], b[31:0], 1'b1, 1'b0));
        muldiv_pkg::op_divuw:  return sext32(div32_ref(a[31:0], b[31:0], 1'b0, 1'b0));
        muldiv_pkg::op_remw:   return sext32(div32_ref(a[31:0], b[31:0], 1'b1, 1'b1));
        muldiv_pkg::op_remuw:  return sext32(div32_ref(a[31:0], b[31:0], 1'b0, 1'b1));
        default:               return '0;
    endcase
endfunction

`endif

// File: verification/muldiv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;
    import muldiv_pkg::*;

    `include "muldiv_model.svh"

    localparam int n_edge = 6;
    localparam int n_rand = 12;
    localparam int n_ops  = 13 * (n_edge * n_edge + n_rand) + 5;

    logic             clk = 1'b0;
    logic             rst_n;
    logic             in_valid;
    muldiv_op_e       op;
    logic [xlen-1:0]  src1;
    logic [xlen-1:0]  src2;
    logic [tag_w-1:0] tag;
    logic             in_ready;
    logic             result_valid;
    logic [tag_w-1:0] result_tag;
    logic [xlen-1:0]  result_data;

    // scoreboard, indexed by tag
    logic [xlen-1:0]  exp_data [32];
    string            exp_name [32];
    int               exp_lat [32];
    int               acc_cyc [32];
    int               res_cyc [32];
    int               issue_seq [32];
    int               done_seq [32];

    int               cyc = 0;
    int               issued_cnt = 0;
    int               done_cnt = 0;
    int               cmp_checks = 0;
    int               cmp_errors = 0;
    int               stim_checks = 0;
    int               stim_errors = 0;
    logic [tag_w-1:0] next_tag = '0;
    logic [tag_w-1:0] rt;
    logic [63:0]      rng_state = 64'd22;

    logic [63:0] edges [n_edge] = '{64'h0, 64'h1, '1, 64'h8000_0000_0000_0000,
                                    64'hffff_ffff_8000_0000, 64'h7fff_ffff_ffff_ffff};
    muldiv_op_e  mul_ops [5] = '{op_mul, op_mulh, op_mulhsu, op_mulhu, op_mulw};
    muldiv_op_e  div_ops [8] = '{op_div, op_divu, op_rem, op_remu,
                                 op_divw, op_divuw, op_remw, op_remuw};

    muldiv_unit dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op           (op),
        .src1         (src1),
        .src2         (src2),
        .tag          (tag),
        .in_ready     (in_ready),
        .result_valid (result_valid),
        .result_tag   (result_tag),
        .result_data  (result_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [63:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    function automatic int solo_latency(input muldiv_op_e o);
        return is_div_op(o) ? 66 : 34;
    endfunction

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic issue_op(input string name, input muldiv_op_e o, input logic [63:0] a,
                            input logic [63:0] b, input int lat,
                            output logic [tag_w-1:0] t);
        t = next_tag;
        next_tag = next_tag + 5'd1;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        op       = o;
        src1     = a;
        src2     = b;
        tag      = t;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        // accepted at the coming edge
        exp_data[t]  = ref_result(o, a, b);
        exp_name[t]  = $sformatf("%s %s", name, o.name());
        exp_lat[t]   = lat;
        acc_cyc[t]   = cyc;
        issue_seq[t] = issue_seq[t] + 1;
        issued_cnt   = issued_cnt + 1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        wait (done_cnt == issued_cnt);
    endtask

    task automatic ready_check(input string name, input logic expected);
        stim_checks = stim_checks + 1;
        assert (in_ready === expected) else begin
            stim_errors = stim_errors + 1;
            $display("[ERROR] %s: expected in_ready %b, actual %b", name, expected, in_ready);
        end
    endtask

    task automatic run_op(input muldiv_op_e o);
        logic [tag_w-1:0] t;
        logic [63:0]      a;
        logic [63:0]      b;
        logic [63:0]      r;
        for (int i = 0; i < n_edge; i++) begin
            for (int j = 0; j < n_edge; j++) begin
                issue_op("edge", o, edges[i], edges[j], solo_latency(o), t);
                wait_drain();
            end
        end
        for (int k = 0; k < n_rand; k++) begin
            a = next_rand();
            r = next_rand();
            // mixed signs and magnitudes for the second operand
            b = $signed(next_rand()) >>> r[5:0];
            issue_op("random", o, a, b, solo_latency(o), t);
            wait_drain();
        end
    endtask

    initial begin
        logic [tag_w-1:0] td;
        logic [tag_w-1:0] tm;
        int               gap;
        int               exp_gap;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = op_mul;
        src1     = '0;
        src2     = '0;
        tag      = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        @(negedge clk);
        ready_check("reset mul", 1'b1);
        stim_checks = stim_checks + 1;
        assert (result_valid === 1'b0) else begin
            stim_errors = stim_errors + 1;
            $display("[ERROR] reset: expected result_valid 0, actual %b", result_valid);
        end
        @(posedge clk);
        #1;
        op = op_div;
        @(negedge clk);
        ready_check("reset div", 1'b1);

        foreach (mul_ops[i]) run_op(mul_ops[i]);
        foreach (div_ops[i]) run_op(div_ops[i]);

        // division and multiplication finishing in the same cycle
        for (int n = 0; n < 2; n++) begin
            // a lone multiplication leaves the multiplier as last served
            if (n == 1) begin
                issue_op("solo", op_mul, next_rand(), next_rand(), solo_latency(op_mul), tm);
                wait_drain();
            end
            issue_op("overlap", op_div, next_rand(), next_rand(), 0, td);
            in_valid = 1'b1;
            op       = op_divu;
            while (cyc < acc_cyc[td] + 31) begin
                @(negedge clk);
                ready_check("overlap busy divider", 1'b0);
                @(posedge clk);
                #1;
            end
            in_valid = 1'b0;
            issue_op("overlap", op_mul, next_rand(), next_rand(), 0, tm);
            wait_drain();
            // engine not served last goes first
            // divider was served last before the first pass
            exp_gap = (n == 0) ? 1 : -1;
            gap = res_cyc[td] - res_cyc[tm];
            stim_checks = stim_checks + 1;
            assert (gap == exp_gap) else begin
                stim_errors = stim_errors + 1;
                $display("[ERROR] overlap order: expected %0d, actual %0d", exp_gap, gap);
            end
        end

        wait_drain();
        $display("checks %0d, errors %0d", cmp_checks + stim_checks, cmp_errors + stim_errors);
        if (cmp_errors + stim_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // compare
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            rt = result_tag;
            cmp_checks = cmp_checks + 1;
            assert (issue_seq[rt] != done_seq[rt]) else begin
                cmp_errors = cmp_errors + 1;
                $display("result for tag %0d arrived with no operation of that tag in flight",
                         rt);
            end
            if (issue_seq[rt] != done_seq[rt]) begin
                cmp_checks = cmp_checks + 1;
                assert (result_data === exp_data[rt]) else begin
                    cmp_errors = cmp_errors + 1;
                    $display("[ERROR] %s: expected %h, actual %h",
                             exp_name[rt], exp_data[rt], result_data);
                end
                if (exp_lat[rt] != 0) begin
                    cmp_checks = cmp_checks + 1;
                    assert (cyc - acc_cyc[rt] == exp_lat[rt]) else begin
                        cmp_errors = cmp_errors + 1;
                        $display("[ERROR] %s latency: expected %0d, actual %0d",
                                 exp_name[rt], exp_lat[rt], cyc - acc_cyc[rt]);
                    end
                end
                res_cyc[rt]  = cyc;
                done_seq[rt] = done_seq[rt] + 1;
                done_cnt     = done_cnt + 1;
            end
        end
    end

    // worst case is every operation a division, plus reset and margin
    initial begin
        repeat (n_ops * 70 + 500) @(posedge clk);
        $display("timeout: only %0d of %0d issued operations returned a result",
                 done_cnt, issued_cnt);
        $display("checks %0d, errors %0d", cmp_checks + stim_checks, cmp_errors + stim_errors);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
